//--- verilog.f
hdl/ooo_pkg.sv
hdl/alu.sv
hdl/result_fifo.sv
hdl/cdb.sv
hdl/alu_iq.sv
hdl/exec_core.sv
tb/tb_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_exec_core
FILELIST  ?= verilog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qxF '*** PASSED ***' sim.log

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_exec_core.sv
module tb_exec_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS    = 5;
    localparam int OPS_PER_TEST = 24;
    localparam int MAX_CYCLES   = NUM_TESTS * OPS_PER_TEST * 20 + 200;
    localparam int NTAGS        = 2 ** ooo_pkg::PREG_W;

    logic                                clk = 1'b0;
    logic                                arst_n_i;
    logic                                flush_i;
    logic [1:0]                          disp_valid_i;
    logic [1:0][ooo_pkg::OP_W-1:0]       disp_op_i;
    logic [1:0][ooo_pkg::PREG_W-1:0]     disp_dst_i;
    ooo_pkg::operand_u [1:0]             disp_src0_i;
    ooo_pkg::operand_u [1:0]             disp_src1_i;
    logic [1:0]                          disp_src0_rdy_i;
    logic [1:0]                          disp_src1_rdy_i;
    logic [1:0]                          disp_ready_o;
    logic [0:0]                          cdb_valid_o;
    logic [0:0][ooo_pkg::PREG_W-1:0]     cdb_tag_o;
    logic [0:0][ooo_pkg::XLEN-1:0]       cdb_data_o;

    logic [NTAGS-1:0]                    pending;  // accepted but not yet broadcast
    logic [NTAGS-1:0][ooo_pkg::XLEN-1:0] exp_val;  // result per destination tag
    logic                                prev_valid;
    logic [ooo_pkg::PREG_W-1:0]          prev_tag;
    logic [ooo_pkg::PREG_W-1:0]          tag_ptr;
    logic                                quiet;    // bus must be idle and queues empty
    bit                                  saw_full;
    int                                  seed = 32'h3904_5ad0;
    int                                  err_cnt = 0;
    int                                  test_cnt = 0;
    int                                  op_cnt = 0;
    int                                  cycles = 0;

    exec_core dut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_op_i       (disp_op_i),
        .disp_dst_i      (disp_dst_i),
        .disp_src0_i     (disp_src0_i),
        .disp_src1_i     (disp_src1_i),
        .disp_src0_rdy_i (disp_src0_rdy_i),
        .disp_src1_rdy_i (disp_src1_rdy_i),
        .disp_ready_o    (disp_ready_o),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_tag_o       (cdb_tag_o),
        .cdb_data_o      (cdb_data_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    a_cdb_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        cdb_valid_o[0] |-> pending[cdb_tag_o[0]])
        else begin
            err_cnt++;
            $display("CHECK FAILED cdb_tag_o: tag %h not in flight", $sampled(cdb_tag_o[0]));
        end
    a_cdb_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        cdb_valid_o[0] |-> cdb_data_o[0] == exp_val[cdb_tag_o[0]])
        else begin
            err_cnt++;
            $display("CHECK FAILED cdb_data_o: tag %h got %h expected %h",
                     $sampled(cdb_tag_o[0]), $sampled(cdb_data_o[0]),
                     exp_val[$sampled(cdb_tag_o[0])]);
        end
    a_quiet_cdb: assert property (@(posedge clk) disable iff (!arst_n_i)
        quiet |-> !cdb_valid_o[0])
        else begin
            err_cnt++;
            $display("CHECK FAILED cdb_valid_o: got %h expected 0", $sampled(cdb_valid_o));
        end
    a_quiet_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        quiet |-> disp_ready_o == 2'b11)
        else begin
            err_cnt++;
            $display("CHECK FAILED disp_ready_o: got %h expected 3", $sampled(disp_ready_o));
        end

    // reference result from the opcode definitions
    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_OR:  return a | b;
            ooo_pkg::OP_XOR: return a ^ b;
            ooo_pkg::OP_SLL: return a << b[4:0];
            ooo_pkg::OP_SRL: return a >> b[4:0];
            default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // slt
        endcase
    endfunction

    // next free tag in round robin order so a retired tag is not reused at once
    function automatic logic [ooo_pkg::PREG_W-1:0] alloc_tag();
        logic [ooo_pkg::PREG_W-1:0] t;
        while (pending[tag_ptr]) tag_ptr++;
        t = tag_ptr;
        tag_ptr++;
        return t;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        disp_valid_i = '0;
        if (prev_valid) pending[prev_tag] = 1'b0; // broadcast last cycle
        prev_valid = cdb_valid_o[0];
        prev_tag   = cdb_tag_o[0];
        if (disp_ready_o != 2'b11) saw_full = 1'b1;
    endtask

    // a value, or a waiting tag whose value comes from the scoreboard
    task automatic make_src(input bit dep, output ooo_pkg::operand_u w, output logic rdy,
                            output logic [31:0] val);
        int                         start;
        logic [ooo_pkg::PREG_W-1:0] t;
        w.value = $random(seed);
        val     = w.value;
        rdy     = 1'b1;
        if (dep && pending != '0 && ($random(seed) & 3) != 0) begin
            start = $random(seed) & (NTAGS - 1);
            t     = '0;
            for (int k = 0; k < NTAGS; k++) begin
                if (pending[(start + k) % NTAGS]) t = ooo_pkg::PREG_W'((start + k) % NTAGS);
            end
            if (cdb_valid_o[0] && ($random(seed) & 1) != 0) t = cdb_tag_o[0]; // same cycle
            w.tag[ooo_pkg::PREG_W-1:0] = t;   // upper bits stay random
            val = exp_val[t];
            rdy = 1'b0;
        end
    endtask

    task automatic dispatch(input int q, input bit dep);
        ooo_pkg::operand_u          w0;
        ooo_pkg::operand_u          w1;
        logic                       r0;
        logic                       r1;
        logic [31:0]                a;
        logic [31:0]                b;
        logic [ooo_pkg::OP_W-1:0]   op;
        logic [ooo_pkg::PREG_W-1:0] dst;
        make_src(dep, w0, r0, a);
        make_src(dep, w1, r1, b);
        op  = ooo_pkg::OP_W'($random(seed));
        dst = alloc_tag();
        disp_valid_i[q]    = 1'b1;
        disp_op_i[q]       = op;
        disp_dst_i[q]      = dst;
        disp_src0_i[q]     = w0;
        disp_src1_i[q]     = w1;
        disp_src0_rdy_i[q] = r0;
        disp_src1_rdy_i[q] = r1;
        exp_val[dst]       = alu_model(op, a, b);
        pending[dst]       = 1'b1;
        op_cnt++;
    endtask

    // both = 1 offers a micro-op to every ready queue each cycle
    task automatic run_stream(input int n, input bit dep, input bit both);
        int sent;
        sent = 0;
        while (sent < n) begin
            next_cycle();
            for (int q = 0; q < 2; q++) begin
                if (sent < n && disp_ready_o[q] && (both || ($random(seed) & 1) != 0)) begin
                    dispatch(q, dep);
                    sent++;
                end
            end
        end
    endtask

    task automatic drain();
        while (pending != '0) next_cycle();
        repeat (4) next_cycle();  // idle bus where nothing stray may show up
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %0d %s: done, %0d failed checks", test_cnt, name, err_cnt - errs_before);
    endtask

    initial begin
        int errs;
        arst_n_i        = 1'b0;
        flush_i         = 1'b0;
        disp_valid_i    = '0;
        disp_op_i       = '0;
        disp_dst_i      = '0;
        disp_src0_i     = '0;
        disp_src1_i     = '0;
        disp_src0_rdy_i = '0;
        disp_src1_rdy_i = '0;
        pending         = '0;
        exp_val         = '0;
        prev_valid      = 1'b0;
        prev_tag        = '0;
        tag_ptr         = '0;
        quiet           = 1'b1;
        saw_full        = 1'b0;

        errs = err_cnt;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;
        repeat (3) next_cycle();
        quiet = 1'b0;
        end_test("reset", errs);

        errs = err_cnt;
        run_stream(OPS_PER_TEST, 1'b0, 1'b0);
        drain();
        end_test("independent", errs);

        errs = err_cnt;
        run_stream(OPS_PER_TEST, 1'b1, 1'b0);
        drain();
        end_test("dependent", errs);

        errs = err_cnt;
        saw_full = 1'b0;
        run_stream(OPS_PER_TEST, 1'b0, 1'b1);
        drain();
        assert (saw_full) else begin
            err_cnt++;
            $display("back-pressure test: no queue ever filled up");
        end
        end_test("back-pressure", errs);

        errs = err_cnt;
        run_stream(OPS_PER_TEST / 2, 1'b1, 1'b1);
        next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i    = 1'b0;
        pending    = '0;    // flushed tags must never appear
        prev_valid = 1'b0;
        quiet      = 1'b1;
        repeat (6) next_cycle();
        quiet = 1'b0;
        run_stream(OPS_PER_TEST, 1'b0, 1'b0);
        drain();
        end_test("flush", errs);

        $display("tests run: %0d, micro-ops: %0d, failed checks: %0d",
                 test_cnt, op_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/exec_core.sv
module exec_core #(
    parameter int IQ_DEPTH   = 4,
    parameter int FIFO_DEPTH = 2,
    parameter int CDB_COUNT  = 1,   // also works with 2
    parameter int PORT_COUNT = 2    // one alu queue per cdb producer
) (
    input  logic                                       clk,
    input  logic                                       arst_n_i,
    input  logic                                       flush_i,

    // dispatch, one slot per queue
    input  logic [PORT_COUNT-1:0]                      disp_valid_i,
    input  logic [PORT_COUNT-1:0][ooo_pkg::OP_W-1:0]   disp_op_i,
    input  logic [PORT_COUNT-1:0][ooo_pkg::PREG_W-1:0] disp_dst_i,
    input  ooo_pkg::operand_u [PORT_COUNT-1:0]         disp_src0_i,
    input  ooo_pkg::operand_u [PORT_COUNT-1:0]         disp_src1_i,
    input  logic [PORT_COUNT-1:0]                      disp_src0_rdy_i,
    input  logic [PORT_COUNT-1:0]                      disp_src1_rdy_i,
    output logic [PORT_COUNT-1:0]                      disp_ready_o,

    // common data bus
    output logic [CDB_COUNT-1:0]                       cdb_valid_o,
    output logic [CDB_COUNT-1:0][ooo_pkg::PREG_W-1:0]  cdb_tag_o,
    output logic [CDB_COUNT-1:0][ooo_pkg::XLEN-1:0]    cdb_data_o
);

    logic [PORT_COUNT-1:0]                      res_valid;
    logic [PORT_COUNT-1:0][ooo_pkg::PREG_W-1:0] res_tag;
    logic [PORT_COUNT-1:0][ooo_pkg::XLEN-1:0]   res_data;
    logic [PORT_COUNT-1:0]                      res_pop;

    for (genvar q = 0; q < PORT_COUNT; q++) begin : g_alu_iq
        alu_iq #(
            .IQ_DEPTH   (IQ_DEPTH),
            .FIFO_DEPTH (FIFO_DEPTH),
            .CDB_COUNT  (CDB_COUNT)
        ) i_alu_iq (
            .clk             (clk),
            .arst_n_i        (arst_n_i),
            .flush_i         (flush_i),
            .disp_valid_i    (disp_valid_i[q]),
            .disp_op_i       (disp_op_i[q]),
            .disp_dst_i      (disp_dst_i[q]),
            .disp_src0_i     (disp_src0_i[q]),
            .disp_src1_i     (disp_src1_i[q]),
            .disp_src0_rdy_i (disp_src0_rdy_i[q]),
            .disp_src1_rdy_i (disp_src1_rdy_i[q]),
            .disp_ready_o    (disp_ready_o[q]),
            .res_valid_o     (res_valid[q]),
            .res_tag_o       (res_tag[q]),
            .res_data_o      (res_data[q]),
            .res_pop_i       (res_pop[q]),
            .cdb_valid_i     (cdb_valid_o),  // broadcasts double as wakeups
            .cdb_tag_i       (cdb_tag_o),
            .cdb_data_i      (cdb_data_o)
        );
    end

    cdb #(
        .PORT_COUNT (PORT_COUNT),
        .CDB_COUNT  (CDB_COUNT)
    ) i_cdb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .src_valid_i (res_valid),
        .src_tag_i   (res_tag),
        .src_data_i  (res_data),
        .src_pop_o   (res_pop),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_data_o  (cdb_data_o)
    );

endmodule

//--- hdl/alu_iq.sv
module alu_iq #(
    parameter int IQ_DEPTH   = 4,
    parameter int FIFO_DEPTH = 2,
    parameter int CDB_COUNT  = 1
) (
    input  logic                                      clk,
    input  logic                                      arst_n_i,
    input  logic                                      flush_i,
    input  logic                                      disp_valid_i,
    input  logic [ooo_pkg::OP_W-1:0]                  disp_op_i,
    input  logic [ooo_pkg::PREG_W-1:0]                disp_dst_i,
    input  ooo_pkg::operand_u                         disp_src0_i,
    input  ooo_pkg::operand_u                         disp_src1_i,
    input  logic                                      disp_src0_rdy_i,
    input  logic                                      disp_src1_rdy_i,
    output logic                                      disp_ready_o,
    output logic                                      res_valid_o,   // fifo head
    output logic [ooo_pkg::PREG_W-1:0]                res_tag_o,
    output logic [ooo_pkg::XLEN-1:0]                  res_data_o,
    input  logic                                      res_pop_i,     // cdb grant
    input  logic [CDB_COUNT-1:0]                      cdb_valid_i,
    input  logic [CDB_COUNT-1:0][ooo_pkg::PREG_W-1:0] cdb_tag_i,
    input  logic [CDB_COUNT-1:0][ooo_pkg::XLEN-1:0]   cdb_data_i
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0]        valid_q;
    logic [ooo_pkg::OP_W-1:0]   op_q   [IQ_DEPTH];
    logic [ooo_pkg::PREG_W-1:0] dst_q  [IQ_DEPTH];
    ooo_pkg::operand_u          src0_q [IQ_DEPTH];
    ooo_pkg::operand_u          src1_q [IQ_DEPTH];
    logic [IQ_DEPTH-1:0]        rdy0_q;
    logic [IQ_DEPTH-1:0]        rdy1_q;

    logic [ooo_pkg::XLEN:0]     snp0 [IQ_DEPTH]; // {hit, value}
    logic [ooo_pkg::XLEN:0]     snp1 [IQ_DEPTH];
    logic [ooo_pkg::XLEN:0]     disp_snp0;
    logic [ooo_pkg::XLEN:0]     disp_snp1;
    ooo_pkg::operand_u          disp_src0;
    ooo_pkg::operand_u          disp_src1;
    logic                       disp_rdy0;
    logic                       disp_rdy1;

    logic [IQ_DEPTH-1:0]        issue_rdy;
    logic [IDX_W-1:0]           alloc_idx;
    logic [IDX_W-1:0]           issue_idx;
    logic                       alloc_fire;
    logic                       issue_fire;
    logic                       fifo_full;
    logic [ooo_pkg::XLEN-1:0]   alu_y;

    // look for a tag among this cycle's broadcasts
    function automatic logic [ooo_pkg::XLEN:0] cdb_snoop(input logic [ooo_pkg::PREG_W-1:0] tag);
        logic [ooo_pkg::XLEN:0] res;
        res = '0;
        for (int l = 0; l < CDB_COUNT; l++) begin
            if (cdb_valid_i[l] && cdb_tag_i[l] == tag) res = {1'b1, cdb_data_i[l]};
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            snp0[i] = cdb_snoop(ooo_pkg::tag_of(src0_q[i]));
            snp1[i] = cdb_snoop(ooo_pkg::tag_of(src1_q[i]));
        end
    end

    // incoming operands may be broadcast in the same cycle
    always_comb begin
        disp_snp0 = cdb_snoop(ooo_pkg::tag_of(disp_src0_i));
        disp_snp1 = cdb_snoop(ooo_pkg::tag_of(disp_src1_i));
        disp_src0 = disp_src0_i;
        disp_src1 = disp_src1_i;
        disp_rdy0 = disp_src0_rdy_i;
        disp_rdy1 = disp_src1_rdy_i;
        if (!disp_src0_rdy_i && disp_snp0[ooo_pkg::XLEN]) begin
            disp_src0.value = disp_snp0[ooo_pkg::XLEN-1:0];
            disp_rdy0       = 1'b1;
        end
        if (!disp_src1_rdy_i && disp_snp1[ooo_pkg::XLEN]) begin
            disp_src1.value = disp_snp1[ooo_pkg::XLEN-1:0];
            disp_rdy1       = 1'b1;
        end
    end

    // lowest free slot and lowest ready entry
    assign issue_rdy = valid_q & rdy0_q & rdy1_q;
    always_comb begin
        alloc_idx = '0;
        issue_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) alloc_idx = IDX_W'(i);
            if (issue_rdy[i]) issue_idx = IDX_W'(i);
        end
    end

    assign disp_ready_o = ~&valid_q;
    assign alloc_fire   = disp_valid_i & disp_ready_o;
    assign issue_fire   = (|issue_rdy) & ~fifo_full;  // full fifo holds the queue

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            if (issue_fire) valid_q[issue_idx] <= 1'b0;
            if (alloc_fire) valid_q[alloc_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (alloc_fire && alloc_idx == IDX_W'(i)) begin
                op_q[i]   <= disp_op_i;
                dst_q[i]  <= disp_dst_i;
                src0_q[i] <= disp_src0;
                src1_q[i] <= disp_src1;
                rdy0_q[i] <= disp_rdy0;
                rdy1_q[i] <= disp_rdy1;
            end else begin
                if (!rdy0_q[i] && snp0[i][ooo_pkg::XLEN]) begin
                    src0_q[i].value <= snp0[i][ooo_pkg::XLEN-1:0]; // tag view replaced
                    rdy0_q[i]       <= 1'b1;
                end
                if (!rdy1_q[i] && snp1[i][ooo_pkg::XLEN]) begin
                    src1_q[i].value <= snp1[i][ooo_pkg::XLEN-1:0];
                    rdy1_q[i]       <= 1'b1;
                end
            end
        end
    end

    alu i_alu (
        .op_i (op_q[issue_idx]),
        .a_i  (src0_q[issue_idx].value),
        .b_i  (src1_q[issue_idx].value),
        .y_o  (alu_y)
    );

    result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_result_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .push_i   (issue_fire),
        .tag_i    (dst_q[issue_idx]),
        .data_i   (alu_y),
        .full_o   (fifo_full),
        .pop_i    (res_pop_i),
        .valid_o  (res_valid_o),
        .tag_o    (res_tag_o),
        .data_o   (res_data_o)
    );

    a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        issue_fire |-> valid_q[issue_idx] && rdy0_q[issue_idx] && rdy1_q[issue_idx]);
    a_alloc_free: assert property (@(posedge clk) disable iff (!arst_n_i)
        alloc_fire |-> !valid_q[alloc_idx]);

endmodule

//--- hdl/cdb.sv
module cdb #(
    parameter int PORT_COUNT = 2,
    parameter int CDB_COUNT  = 1
) (
    input  logic                                          clk,
    input  logic                                          arst_n_i,
    input  logic                                          flush_i,
    input  logic [PORT_COUNT-1:0]                         src_valid_i,
    input  logic [PORT_COUNT-1:0][ooo_pkg::PREG_W-1:0]    src_tag_i,
    input  logic [PORT_COUNT-1:0][ooo_pkg::XLEN-1:0]      src_data_i,
    output logic [PORT_COUNT-1:0]                         src_pop_o,
    output logic [CDB_COUNT-1:0]                          cdb_valid_o,
    output logic [CDB_COUNT-1:0][ooo_pkg::PREG_W-1:0]     cdb_tag_o,
    output logic [CDB_COUNT-1:0][ooo_pkg::XLEN-1:0]       cdb_data_o
);

    localparam int RR_W = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;

    logic [RR_W-1:0] rr_q;     // first port to look at
    logic [RR_W-1:0] rr_next;

    // walk the ports from rr_q, filling lanes in order
    always_comb begin
        int p;
        int lane;
        src_pop_o   = '0;
        cdb_valid_o = '0;
        cdb_tag_o   = '0;
        cdb_data_o  = '0;
        rr_next     = rr_q;
        lane        = 0;
        for (int k = 0; k < PORT_COUNT; k++) begin
            p = int'(rr_q) + k;
            if (p >= PORT_COUNT) p = p - PORT_COUNT;
            if (src_valid_i[p] && lane < CDB_COUNT) begin
                src_pop_o[p]      = 1'b1;
                cdb_valid_o[lane] = 1'b1;
                cdb_tag_o[lane]   = src_tag_i[p];
                cdb_data_o[lane]  = src_data_i[p];
                rr_next = (p == PORT_COUNT - 1) ? '0 : RR_W'(p + 1); // past last grant
                lane    = lane + 1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q <= '0;
        end else if (flush_i) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_next;
        end
    end

    // destination tags in flight are unique, so two lanes never collide
    for (genvar l0 = 0; l0 < CDB_COUNT; l0++) begin : g_lane_chk
        for (genvar l1 = l0 + 1; l1 < CDB_COUNT; l1++) begin : g_pair
            a_lane_tag_unique: assert property (@(posedge clk) disable iff (!arst_n_i)
                !(cdb_valid_o[l0] && cdb_valid_o[l1] && cdb_tag_o[l0] == cdb_tag_o[l1]));
        end
    end

    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_pop_chk
        a_pop_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
            src_pop_o[p] |-> src_valid_i[p]);
    end

endmodule

//--- hdl/result_fifo.sv
module result_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        flush_i,
    input  logic                        push_i,
    input  logic [ooo_pkg::PREG_W-1:0]  tag_i,
    input  logic [ooo_pkg::XLEN-1:0]    data_i,
    output logic                        full_o,
    input  logic                        pop_i,
    output logic                        valid_o,
    output logic [ooo_pkg::PREG_W-1:0]  tag_o,
    output logic [ooo_pkg::XLEN-1:0]    data_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ooo_pkg::PREG_W-1:0] tag_mem  [FIFO_DEPTH];
    logic [ooo_pkg::XLEN-1:0]   data_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [CNT_W-1:0]           count_q;
    logic                       do_push;
    logic                       do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    assign valid_o = (count_q != '0);
    assign tag_o   = tag_mem[rd_ptr_q];   // head, no bypass from push
    assign data_o  = data_mem[rd_ptr_q];
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            tag_mem[wr_ptr_q]  <= tag_i;
            data_mem[wr_ptr_q] <= data_i;
        end
    end

    // the queue holds issue while full, the cdb only grants a valid head
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        pop_i |-> valid_o);

endmodule

//--- hdl/alu.sv
module alu (
    input  logic [ooo_pkg::OP_W-1:0] op_i,
    input  logic [ooo_pkg::XLEN-1:0] a_i,  // src0
    input  logic [ooo_pkg::XLEN-1:0] b_i,  // src1
    output logic [ooo_pkg::XLEN-1:0] y_o
);

    logic                     sub;
    logic [ooo_pkg::XLEN-1:0] b_eff;
    logic [ooo_pkg::XLEN-1:0] sum;
    logic [4:0]               shamt;
    logic                     lt;

    // add, sub and slt share one adder
    assign sub   = (op_i == ooo_pkg::OP_SUB) || (op_i == ooo_pkg::OP_SLT);
    assign b_eff = sub ? ~b_i : b_i;
    assign sum   = a_i + b_eff + {{(ooo_pkg::XLEN-1){1'b0}}, sub};
    assign shamt = b_i[4:0];

    // when the signs differ the negative operand is the smaller one
    // with equal signs the difference cannot overflow and its sign decides
    assign lt = (a_i[ooo_pkg::XLEN-1] != b_i[ooo_pkg::XLEN-1]) ?
                a_i[ooo_pkg::XLEN-1] : sum[ooo_pkg::XLEN-1];

    always_comb begin
        case (op_i)
            ooo_pkg::OP_ADD: y_o = sum;
            ooo_pkg::OP_SUB: y_o = sum;
            ooo_pkg::OP_AND: y_o = a_i & b_i;
            ooo_pkg::OP_OR:  y_o = a_i | b_i;
            ooo_pkg::OP_XOR: y_o = a_i ^ b_i;
            ooo_pkg::OP_SLL: y_o = a_i << shamt;
            ooo_pkg::OP_SRL: y_o = a_i >> shamt;
            ooo_pkg::OP_SLT: y_o = {{(ooo_pkg::XLEN-1){1'b0}}, lt};
            default:         y_o = '0;
        endcase
    end

endmodule

//--- hdl/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN   = 32; // data word
    localparam int PREG_W = 6;  // physical register tag
    localparam int OP_W   = 3;

    // alu opcodes
    localparam logic [OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [OP_W-1:0] OP_AND = 3'd2;
    localparam logic [OP_W-1:0] OP_OR  = 3'd3;
    localparam logic [OP_W-1:0] OP_XOR = 3'd4;
    localparam logic [OP_W-1:0] OP_SLL = 3'd5; // shift by src1[4:0]
    localparam logic [OP_W-1:0] OP_SRL = 3'd6; // logical shift by src1[4:0]
    localparam logic [OP_W-1:0] OP_SLT = 3'd7; // signed compare giving 1 or 0

    // one source operand word
    // while the ready bit is low it holds the producer tag, afterwards the value
    typedef union packed {
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] tag;   // only the low PREG_W bits count
    } operand_u;

    // producer register named by the tag view
    function automatic logic [PREG_W-1:0] tag_of(input operand_u w);
        return w.tag[PREG_W-1:0];
    endfunction

endpackage
